// ==== src/huge_page_regs.sv ====
// Rx huge page slots
`timescale 1ns/1ps
`include "nic_macros.svh"

module huge_page_regs
    import nic_regs_pkg::*;
(
    input  logic               trn_clk,
    input  logic               reset,
    reg_wr_if.dst              wr,
    input  logic               page_done,
    output logic [`DATA_W-1:0] page_addr,
    output logic               page_valid,
    output logic               page_freed
);

    logic [`DATA_W-1:0] addr_q [2];          // Host addresses per slot
    logic [1:0]         ready_q;             // Slot owned by hardware
    page_slot_t         cur_slot;            // Slot being filled
    page_slot_t         wr_slot;
    logic               wr_hit;

    // ---------------------------------------------------------------------
    // Register write decode
    // ---------------------------------------------------------------------
    assign wr_hit  = wr.wr_stb && wr.len_ok &&
                     (wr.offset == PAGE1_ADDR || wr.offset == PAGE2_ADDR);
    assign wr_slot = page_slot_t'(wr.offset == PAGE2_ADDR);

    always_ff @(posedge trn_clk) begin
        if (wr_hit) begin
            addr_q[wr_slot] <= wr.data.addr; // Address view of the word
        end
    end

    // ---------------------------------------------------------------------
    // Ready flags and slot rotation
    // ---------------------------------------------------------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            ready_q    <= 2'b00;
            cur_slot   <= 1'b1;              // First rotation lands on slot 1
            page_freed <= 1'b0;
        end else begin
            page_freed <= page_done;
            if (page_done) begin
                ready_q[cur_slot] <= 1'b0;   // Hand page back to host
                cur_slot          <= ~cur_slot;
            end
            if (wr_hit) begin
                ready_q[wr_slot] <= 1'b1;    // New page wins over a same-cycle free
            end
        end
    end

    assign page_addr  = addr_q[cur_slot];
    assign page_valid = ready_q[cur_slot];

    // Packet writer only finishes a page it was given
    a_done_needs_valid : assert property (
        @(posedge trn_clk) disable iff (reset)
        page_done |-> page_valid
    );

endmodule

// ==== src/interrupt_fsm.sv ====
// Legacy interrupt request FSM
`timescale 1ns/1ps
`include "nic_macros.svh"

module interrupt_fsm (
    input  logic trn_clk,
    input  logic reset,
    input  logic page_freed,
    output logic cfg_interrupt_n,
    input  logic cfg_interrupt_rdy_n
);

    localparam logic [1:0] IDLE    = 2'd0;
    localparam logic [1:0] ASSERT  = 2'd1;   // Request held toward the core
    localparam logic [1:0] HOLDOFF = 2'd2;   // Enforced quiet time
    localparam int         CNT_W   = $clog2(`INT_HOLDOFF);

    logic [1:0]       state_q;
    logic             pending_q;             // Merged requests waiting
    logic [CNT_W-1:0] holdoff_q;

    // ---------------------------------------------------------------------
    // State machine
    // ---------------------------------------------------------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state_q         <= IDLE;
            pending_q       <= 1'b0;
            holdoff_q       <= '0;
            cfg_interrupt_n <= 1'b1;
        end else begin
            pending_q <= pending_q || page_freed;
            case (state_q)
                IDLE: begin
                    if (pending_q) begin
                        state_q         <= ASSERT;
                        pending_q       <= page_freed;   // Consume one request
                        cfg_interrupt_n <= 1'b0;
                    end
                end
                ASSERT: begin
                    if (!cfg_interrupt_rdy_n) begin
                        state_q         <= HOLDOFF;      // Core took the interrupt
                        cfg_interrupt_n <= 1'b1;
                        holdoff_q       <= CNT_W'(`INT_HOLDOFF - 1);
                    end
                end
                HOLDOFF: begin
                    if (holdoff_q == '0) begin
                        state_q <= IDLE;
                    end else begin
                        holdoff_q <= holdoff_q - 1'b1;
                    end
                end
                default: begin
                    state_q         <= IDLE;
                    cfg_interrupt_n <= 1'b1;
                end
            endcase
        end
    end

    // Once acknowledged the request line stays quiet for the hold-off
    a_holdoff_quiet : assert property (
        @(posedge trn_clk) disable iff (reset)
        (!cfg_interrupt_n && !cfg_interrupt_rdy_n) |=> cfg_interrupt_n [*`INT_HOLDOFF]
    );

endmodule

// ==== src/nic_macros.svh ====
// NIC control path constants
`ifndef NIC_MACROS_SVH
`define NIC_MACROS_SVH

// ---------------------------------------------------------------------
// Datapath
// ---------------------------------------------------------------------
`define DATA_W          64                   // Rx link and register word width
`define REG_BAR         2                    // BAR hit bit for register space

// ---------------------------------------------------------------------
// Timing
// ---------------------------------------------------------------------
`define NSECS_PER_TICK  32'd4                // 250 MHz trn_clk
`define NSECS_PER_SEC   32'd1000000000       // Nanosecond wrap point
`define INT_HOLDOFF     16                   // Min idle cycles between interrupts

`endif

// ==== src/nic_regs_pkg.sv ====
// NIC register map types
`include "nic_macros.svh"

package nic_regs_pkg;

    // ---------------------------------------------------------------------
    // Register offsets in the register BAR
    // ---------------------------------------------------------------------
    typedef logic [7:0] reg_offset_t;

    localparam reg_offset_t PAGE1_ADDR = 8'h00;  // Rx huge page slot 1
    localparam reg_offset_t PAGE2_ADDR = 8'h08;  // Rx huge page slot 2
    localparam reg_offset_t SYS_TIME   = 8'h10;  // Secs and nsecs load
    localparam reg_offset_t RX_CTRL    = 8'h18;  // Bit 0 timestamp enable

    typedef logic page_slot_t;               // 0 = slot 1, 1 = slot 2

    // ---------------------------------------------------------------------
    // Register payload word
    // ---------------------------------------------------------------------
    typedef struct packed {
        logic [`DATA_W/2-1:0] secs;          // Upper half
        logic [`DATA_W/2-1:0] nsecs;         // Lower half
    } time_word_t;

    // Page writes use addr, time writes use tm
    typedef union packed {
        logic [`DATA_W-1:0] addr;
        time_word_t         tm;
    } reg_data_u;

endpackage

// ==== src/pcie_ep_driver.sv ====
// PCIe endpoint control path
`timescale 1ns/1ps
`include "nic_macros.svh"

module pcie_ep_driver (
    input  logic                 trn_clk,
    input  logic                 reset,

    // Rx local-link
    input  logic [`DATA_W-1:0]   trn_rd,
    input  logic                 trn_rsof_n,
    input  logic                 trn_reof_n,
    input  logic                 trn_rsrc_rdy_n,
    input  logic                 trn_rsrc_dsc_n,
    input  logic [6:0]           trn_rbar_hit_n,

    // Packet writer side
    input  logic                 page_done,
    output logic [`DATA_W-1:0]   page_addr,
    output logic                 page_valid,
    output logic [`DATA_W/2-1:0] sys_nsecs,
    output logic [`DATA_W/2-1:0] sys_secs,
    output logic                 rx_timestamp_en,

    // Configuration interrupt
    output logic                 cfg_interrupt_n,
    input  logic                 cfg_interrupt_rdy_n
);

    // ---------------------------------------------------------------------
    // Register writes from the host
    // ---------------------------------------------------------------------
    reg_wr_if wr_bus ();

    logic page_freed;                        // Slot handed back

    tlp_rx_decoder tlp_rx_decoder_i (
        .trn_clk        (trn_clk),
        .reset          (reset),
        .trn_rd         (trn_rd),
        .trn_rsof_n     (trn_rsof_n),
        .trn_reof_n     (trn_reof_n),
        .trn_rsrc_rdy_n (trn_rsrc_rdy_n),
        .trn_rsrc_dsc_n (trn_rsrc_dsc_n),
        .trn_rbar_hit_n (trn_rbar_hit_n),
        .wr             (wr_bus.src)
    );

    huge_page_regs huge_page_regs_i (
        .trn_clk    (trn_clk),
        .reset      (reset),
        .wr         (wr_bus.dst),
        .page_done  (page_done),
        .page_addr  (page_addr),
        .page_valid (page_valid),
        .page_freed (page_freed)
    );

    sys_time sys_time_i (
        .trn_clk         (trn_clk),
        .reset           (reset),
        .wr              (wr_bus.dst),
        .sys_nsecs       (sys_nsecs),
        .sys_secs        (sys_secs),
        .rx_timestamp_en (rx_timestamp_en)
    );

    // ---------------------------------------------------------------------
    // Interrupt toward the PCIe core
    // ---------------------------------------------------------------------
    interrupt_fsm interrupt_fsm_i (
        .trn_clk             (trn_clk),
        .reset               (reset),
        .page_freed          (page_freed),
        .cfg_interrupt_n     (cfg_interrupt_n),
        .cfg_interrupt_rdy_n (cfg_interrupt_rdy_n)
    );

endmodule

// ==== src/pcie_tlp_pkg.sv ====
// PCIe TLP header types
package pcie_tlp_pkg;

    // ---------------------------------------------------------------------
    // Format and type
    // ---------------------------------------------------------------------
    typedef logic [6:0] tlp_fmt_type_t;      // fmt[1:0] followed by type[4:0]

    // fmt 2'b10 = 3DW header with data, type 5'b00000 = memory request
    localparam tlp_fmt_type_t MWR32_DATA = 7'b10_00000;

    // ---------------------------------------------------------------------
    // First header DW, bit 31 down to bit 0
    // ---------------------------------------------------------------------
    typedef struct packed {
        logic          rsvd0;                // Bit 31
        tlp_fmt_type_t fmt_type;             // Bits 30:24
        logic          rsvd1;
        logic [2:0]    tc;                   // Traffic class
        logic [3:0]    rsvd2;
        logic          td;                   // Digest present
        logic          ep;                   // Poisoned
        logic [1:0]    attr;                 // Ordering and snoop
        logic [1:0]    rsvd3;
        logic [9:0]    length;               // Payload length in DW
    } tlp_dw0_t;

endpackage

// ==== src/reg_wr_if.sv ====
// Register write channel
`timescale 1ns/1ps

interface reg_wr_if
    import nic_regs_pkg::*;
();

    logic        wr_stb;                     // One cycle, no back-pressure
    reg_offset_t offset;                     // Valid with wr_stb
    reg_data_u   data;                       // Valid with wr_stb
    logic        len_ok;                     // TLP carried exactly 2 DW

    modport src (output wr_stb, offset, data, len_ok);
    modport dst (input wr_stb, offset, data, len_ok);

endinterface

// ==== src/sys_time.sv ====
// System time counter
`timescale 1ns/1ps
`include "nic_macros.svh"

module sys_time
    import nic_regs_pkg::*;
(
    input  logic                 trn_clk,
    input  logic                 reset,
    reg_wr_if.dst                wr,
    output logic [`DATA_W/2-1:0] sys_nsecs,
    output logic [`DATA_W/2-1:0] sys_secs,
    output logic                 rx_timestamp_en
);

    logic [`DATA_W/2-1:0] nsecs_sum;
    logic                 load_time;
    logic                 load_ctrl;

    assign nsecs_sum = sys_nsecs + `NSECS_PER_TICK;
    assign load_time = wr.wr_stb && wr.len_ok && (wr.offset == SYS_TIME);
    assign load_ctrl = wr.wr_stb && wr.len_ok && (wr.offset == RX_CTRL);

    // ---------------------------------------------------------------------
    // Counter with nanosecond wrap
    // ---------------------------------------------------------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            sys_nsecs       <= '0;
            sys_secs        <= '0;
            rx_timestamp_en <= 1'b0;
        end else begin
            if (load_time) begin
                sys_nsecs <= wr.data.tm.nsecs;   // Time view of the word
                sys_secs  <= wr.data.tm.secs;
            end else if (nsecs_sum >= `NSECS_PER_SEC) begin
                sys_nsecs <= nsecs_sum - `NSECS_PER_SEC;
                sys_secs  <= sys_secs + 1'b1;    // Carry into seconds
            end else begin
                sys_nsecs <= nsecs_sum;
            end
            if (load_ctrl) begin
                rx_timestamp_en <= wr.data.addr[0];
            end
        end
    end

    // Host loads only nanosecond values below one second
    a_nsecs_in_range : assert property (
        @(posedge trn_clk) disable iff (reset)
        sys_nsecs < `NSECS_PER_SEC
    );

endmodule

// ==== src/tlp_rx_decoder.sv ====
// Rx memory write decoder
`timescale 1ns/1ps
`include "nic_macros.svh"

module tlp_rx_decoder
    import pcie_tlp_pkg::*;
    import nic_regs_pkg::*;
(
    input  logic               trn_clk,
    input  logic               reset,
    input  logic [`DATA_W-1:0] trn_rd,
    input  logic               trn_rsof_n,
    input  logic               trn_reof_n,
    input  logic               trn_rsrc_rdy_n,
    input  logic               trn_rsrc_dsc_n,
    input  logic [6:0]         trn_rbar_hit_n,
    reg_wr_if.src              wr
);

    // ---------------------------------------------------------------------
    // Beat qualification
    // ---------------------------------------------------------------------
    tlp_dw0_t    dw0;
    logic        beat_ok;
    logic        sof;
    logic        eof;
    logic        hdr_keep;
    logic        keep_now;
    logic        len_now;

    logic        open_q;                     // TLP started, eof not yet seen
    logic        keep_q;                     // TLP still a candidate write
    logic        len_ok_q;                   // Header length was 2 DW
    logic [1:0]  beat_q;                     // Index of the next beat
    logic [31:0] dw_a_q;                     // Lower payload DW
    reg_offset_t offset_q;

    assign dw0      = tlp_dw0_t'(trn_rd[63:32]);
    assign beat_ok  = !trn_rsrc_rdy_n;
    assign sof      = beat_ok && !trn_rsof_n;
    assign eof      = beat_ok && !trn_reof_n;
    assign hdr_keep = (dw0.fmt_type == MWR32_DATA) && !trn_rbar_hit_n[`REG_BAR];
    assign keep_now = (sof ? hdr_keep : keep_q) && trn_rsrc_dsc_n;  // Discontinue kills
    assign len_now  = sof ? (dw0.length == 10'd2) : len_ok_q;

    // ---------------------------------------------------------------------
    // TLP tracking
    // ---------------------------------------------------------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            open_q   <= 1'b0;
            keep_q   <= 1'b0;
            len_ok_q <= 1'b0;
            beat_q   <= 2'd0;
        end else begin
            keep_q   <= keep_now;
            len_ok_q <= len_now;
            if (!trn_rsrc_dsc_n) begin
                open_q <= 1'b0;              // Abandon the TLP
            end else if (sof && !eof) begin
                open_q <= 1'b1;
            end else if (eof) begin
                open_q <= 1'b0;
            end
            if (sof) begin
                beat_q <= 2'd1;
            end else if (beat_ok && beat_q != 2'd3) begin
                beat_q <= beat_q + 2'd1;     // Saturates on long TLPs
            end
        end
    end

    // Address DW and DW A sit in beat 1
    always_ff @(posedge trn_clk) begin
        if (beat_ok && !sof && beat_q == 2'd1) begin
            offset_q <= reg_offset_t'(trn_rd[39:32]);
            dw_a_q   <= trn_rd[31:0];
        end
    end

    // ---------------------------------------------------------------------
    // Write strobe, one cycle after eof
    // ---------------------------------------------------------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            wr.wr_stb <= 1'b0;
        end else begin
            wr.wr_stb <= eof && keep_now;
        end
    end

    always_ff @(posedge trn_clk) begin
        if (eof) begin
            wr.offset <= offset_q;
            wr.data   <= {trn_rd[63:32], dw_a_q};            // DW B above DW A
            wr.len_ok <= len_now && !sof && (beat_q == 2'd2);  // eof must be beat 2
        end
    end

    // Each TLP closes before the next one starts
    a_no_sof_while_open : assert property (
        @(posedge trn_clk) disable iff (reset)
        sof |-> !open_q
    );

endmodule

// ==== tests/tb_pcie_ep_driver.sv ====
// PCIe endpoint control path testbench
`timescale 1ns/1ps
`include "nic_macros.svh"

module tb_pcie_ep_driver
    import pcie_tlp_pkg::*;
    import nic_regs_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;    // Roughly ten times the full sequence

    logic                 trn_clk;
    logic                 reset;
    logic [`DATA_W-1:0]   trn_rd;
    logic                 trn_rsof_n;
    logic                 trn_reof_n;
    logic                 trn_rsrc_rdy_n;
    logic                 trn_rsrc_dsc_n;
    logic [6:0]           trn_rbar_hit_n;
    logic                 page_done;
    logic [`DATA_W-1:0]   page_addr;
    logic                 page_valid;
    logic [`DATA_W/2-1:0] sys_nsecs;
    logic [`DATA_W/2-1:0] sys_secs;
    logic                 rx_timestamp_en;
    logic                 cfg_interrupt_n;
    logic                 cfg_interrupt_rdy_n;

    logic [31:0]          lfsr_q;            // Shared random state
    int                   irq_count;         // Interrupts acknowledged so far
    int                   cycle_cnt;

    pcie_ep_driver dut0 (.*);

    // ---------------------------------------------------------------------
    // Clock, random source, failure report
    // ---------------------------------------------------------------------
    initial begin
        trn_clk = 1'b0;
        forever #5 trn_clk = ~trn_clk;       // 100 MHz in simulation
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[62:0], fb};
        end
        return v;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // ---------------------------------------------------------------------
    // Stimulus tasks
    // ---------------------------------------------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge trn_clk);
            #1;
        end
    endtask

    // Three beat memory write where dsc_beat 3 means no discontinue
    task automatic send_mwr(input reg_offset_t offset, input logic [63:0] data,
                            input int bar, input tlp_fmt_type_t fmt_type,
                            input logic [9:0] length, input int dsc_beat);
        tlp_dw0_t    dw0;
        logic [63:0] beats [3];
        int          gap;
        dw0          = '0;
        dw0.fmt_type = fmt_type;
        dw0.length   = length;
        beats[0]     = {dw0, 32'h0000_00ff};                  // DW1 with byte enables
        beats[1]     = {32'hf000_0000 | {24'h0, offset}, data[31:0]};
        beats[2]     = {data[63:32], 32'h0};
        for (int b = 0; b < 3; b++) begin
            gap = int'(rand_bits(2));
            repeat (gap) begin
                trn_rsrc_rdy_n = 1'b1;       // Idle beat
                trn_rsrc_dsc_n = 1'b1;
                @(posedge trn_clk);
                #1;
            end
            trn_rd         = beats[b];
            trn_rsof_n     = (b != 0);
            trn_reof_n     = (b != 2);
            trn_rsrc_rdy_n = 1'b0;
            trn_rsrc_dsc_n = (b != dsc_beat);
            trn_rbar_hit_n = ~(7'd1 << bar);
            @(posedge trn_clk);
            #1;
        end
        trn_rsrc_rdy_n = 1'b1;
        trn_rsof_n     = 1'b1;
        trn_reof_n     = 1'b1;
        trn_rsrc_dsc_n = 1'b1;
    endtask

    task automatic write_reg(input reg_offset_t offset, input logic [63:0] data);
        send_mwr(offset, data, `REG_BAR, MWR32_DATA, 10'd2, 3);
    endtask

    task automatic pulse_page_done();
        page_done = 1'b1;
        @(posedge trn_clk);
        #1;
        page_done = 1'b0;
    endtask

    task automatic wait_irqs(input int target);
        while (irq_count < target) begin
            @(posedge trn_clk);
            #1;
        end
    endtask

    // ---------------------------------------------------------------------
    // Interrupt responder and watchdog
    // ---------------------------------------------------------------------
    initial begin
        int delay;
        forever begin
            @(posedge trn_clk);
            #1;
            if (!reset && !cfg_interrupt_n) begin
                delay = 1 + int'(rand_bits(3));  // Core latency 1 to 8 cycles
                wait_cycles(delay);
                cfg_interrupt_rdy_n = 1'b0;
                wait_cycles(1);
                cfg_interrupt_rdy_n = 1'b1;
                irq_count++;
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge trn_clk);
            cycle_cnt++;
        end
        $display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAIL");
        $fatal(1);
    end

    // ---------------------------------------------------------------------
    // Interrupt protocol checks
    // ---------------------------------------------------------------------
    a_irq_held : assert property (@(posedge trn_clk) disable iff (reset)
        (!cfg_interrupt_n && cfg_interrupt_rdy_n) |=> !cfg_interrupt_n)
        else report_mismatch("cfg_interrupt_n rose before cfg_interrupt_rdy_n");

    a_irq_release : assert property (@(posedge trn_clk) disable iff (reset)
        (!cfg_interrupt_n && !cfg_interrupt_rdy_n) |=> cfg_interrupt_n)
        else report_mismatch("cfg_interrupt_n still low after cfg_interrupt_rdy_n");

    a_irq_holdoff : assert property (@(posedge trn_clk) disable iff (reset)
        $rose(cfg_interrupt_n) |-> cfg_interrupt_n [*`INT_HOLDOFF])
        else report_mismatch("interrupt hold-off shorter than INT_HOLDOFF");

    a_done_irq : assert property (@(posedge trn_clk) disable iff (reset)
        page_done |-> ##[3:40] !cfg_interrupt_n)
        else report_mismatch("no interrupt after page_done");

    // ---------------------------------------------------------------------
    // Main sequence
    // ---------------------------------------------------------------------
    initial begin
        logic [63:0] addr1;
        logic [63:0] addr2;
        logic [31:0] secs;
        lfsr_q              = 32'hd79c_a17b;
        irq_count           = 0;
        reset               = 1'b1;
        trn_rd              = '0;
        trn_rsof_n          = 1'b1;
        trn_reof_n          = 1'b1;
        trn_rsrc_rdy_n      = 1'b1;
        trn_rsrc_dsc_n      = 1'b1;
        trn_rbar_hit_n      = 7'h7f;
        page_done           = 1'b0;
        cfg_interrupt_rdy_n = 1'b1;
        repeat (2) @(posedge trn_clk);
        #1;
        reset = 1'b0;

        assert (cfg_interrupt_n && !page_valid && !rx_timestamp_en &&
                sys_secs == '0 && sys_nsecs == '0)
            else report_mismatch("outputs not at reset values");

        // Page slots and rotation
        addr1 = rand_bits(64);
        addr2 = rand_bits(64);
        write_reg(PAGE1_ADDR, addr1);
        wait_cycles(1);
        assert (!page_valid) else report_mismatch("page_valid set by slot 1 write");
        write_reg(PAGE2_ADDR, addr2);
        wait_cycles(1);
        assert (page_valid && page_addr == addr2)
            else report_mismatch("slot 2 not current after its write");
        pulse_page_done();
        assert (page_valid && page_addr == addr1)
            else report_mismatch("page_addr not slot 1 address after page_done");
        wait_irqs(1);
        pulse_page_done();                   // Lands inside the hold-off
        assert (!page_valid && page_addr == addr2)
            else report_mismatch("page_addr not slot 2 address after second page_done");
        wait_irqs(2);

        // TLPs that must be dropped
        send_mwr(PAGE2_ADDR, ~addr2, 0, MWR32_DATA, 10'd2, 3);
        send_mwr(RX_CTRL, 64'd1, 1, MWR32_DATA, 10'd2, 3);
        send_mwr(PAGE2_ADDR, ~addr2, `REG_BAR, 7'b00_00000, 10'd2, 3);
        send_mwr(PAGE2_ADDR, ~addr2, `REG_BAR, MWR32_DATA, 10'd3, 3);
        send_mwr(RX_CTRL, 64'd1, `REG_BAR, MWR32_DATA, 10'd2, 1);
        wait_cycles(2);
        assert (!page_valid && page_addr == addr2 && !rx_timestamp_en)
            else report_mismatch("ignored TLP changed an output");

        // Time load and second carry
        secs = 32'(rand_bits(32));
        write_reg(SYS_TIME, {secs, `NSECS_PER_SEC - 32'd8});
        wait_cycles(1);
        assert (sys_secs == secs && sys_nsecs == `NSECS_PER_SEC - 32'd8)
            else report_mismatch("system time not loaded 2 cycles after eof");
        wait_cycles(2);
        assert (sys_secs == secs + 32'd1 && sys_nsecs == '0)
            else report_mismatch("nanosecond wrap did not carry into seconds");

        // Timestamp enable
        write_reg(RX_CTRL, 64'd1);
        wait_cycles(1);
        assert (rx_timestamp_en) else report_mismatch("rx_timestamp_en not set");
        write_reg(RX_CTRL, 64'd0);
        wait_cycles(1);
        assert (!rx_timestamp_en) else report_mismatch("rx_timestamp_en not cleared");

        wait_cycles(4);
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+src
src/pcie_tlp_pkg.sv
src/nic_regs_pkg.sv
src/reg_wr_if.sv
src/tlp_rx_decoder.sv
src/huge_page_regs.sv
src/sys_time.sv
src/interrupt_fsm.sv
src/pcie_ep_driver.sv
tests/tb_pcie_ep_driver.sv
